// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the calculator testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module calc_tb -o calc_sim || { echo "Build failed"; exit 1; }
sim_out="$(./obj_dir/calc_sim)"
echo "$sim_out"
grep -qx "PASS: all tests" <<< "$sim_out" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// File: source/calc_control.sv
`timescale 1ns/1ps

module calc_control #(
    parameter int Width = calc_pkg::calc_width      // Operand width
) (
    input  logic                clk,
    input  logic                nRST,
    input  calc_pkg::op_e       operator,           // One-hot operator key
    input  logic                equal,              // Equal key
    input  logic [Width-1:0]    value_a,            // From first accumulator
    input  logic [Width-1:0]    value_b,            // From second accumulator
    input  logic                add_done,
    input  logic                mul_done,
    input  logic [Width-1:0]    add_result,
    input  logic [Width-1:0]    mul_result,
    output logic                enter_a,            // Collect first operand
    output logic                enter_b,            // Collect second operand
    output logic                clear,              // Empty both accumulators
    output logic                start_add,          // Launch adder/subtractor
    output logic                start_mul,          // Launch multiplier
    output logic                sub,                // Subtract select
    output calc_pkg::operands_t operands,           // Operand pair to units
    output logic                complete,           // One-cycle result strobe
    output logic [Width-1:0]    result              // Last computed value
);

    typedef enum logic [2:0] {
        get_first,                                  // Digits of a and operator
        get_second,                                 // Digits of b until equal
        issue,                                      // Fire one start pulse
        wait_done,                                  // Unit running
        show                                        // Result strobe and clear
    } state_t;

    state_t           state;
    state_t           next_state;
    calc_pkg::op_e    op_q;                         // Latched operator
    logic             op_valid;                     // Legal one-hot key
    logic             is_mul;                       // Multiplier path chosen
    logic             unit_done;                    // done of the chosen unit
    logic [Width-1:0] unit_result;                  // Result of the chosen unit

    assign op_valid = (operator == calc_pkg::op_add)
                   || (operator == calc_pkg::op_sub)
                   || (operator == calc_pkg::op_mul);
    assign is_mul      = (op_q == calc_pkg::op_mul);
    assign unit_done   = is_mul ? mul_done : add_done;
    assign unit_result = is_mul ? mul_result : add_result;

    // Next state
    always_comb begin
        next_state = state;
        case (state)
            get_first:  if (op_valid) next_state = get_second;
            get_second: if (equal) next_state = issue;
            issue:      next_state = wait_done;     // Start lasts one cycle
            wait_done:  if (unit_done) next_state = show;
            show:       next_state = get_first;
            default:    next_state = get_first;
        endcase
    end

    // State, operator and result registers
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state  <= get_first;
            op_q   <= calc_pkg::op_none;
            result <= '0;
        end else begin
            state <= next_state;
            if (state == get_first && op_valid) begin
                op_q <= operator;                   // Held until next get_first
            end
            if (state == wait_done && unit_done) begin
                result <= unit_result;              // Kept until next completion
            end
        end
    end

    // Decoded outputs
    assign enter_a   = (state == get_first);
    assign enter_b   = (state == get_second);
    assign clear     = (state == show);
    assign complete  = (state == show);
    assign start_add = (state == issue) && !is_mul;
    assign start_mul = (state == issue) && is_mul;
    assign sub       = (op_q == calc_pkg::op_sub);
    assign operands  = '{a: value_a, b: value_b};   // Accumulators hold still here

    // Adder finishes only inside an add or subtract run
    a_add_done_expected: assert property (
        @(posedge clk) disable iff (!nRST)
        add_done |-> ((state == wait_done) && !is_mul)
    ) else $error("calc_control got add_done outside an add or subtract");

    // Multiplier finishes only inside a multiply run
    a_mul_done_expected: assert property (
        @(posedge clk) disable iff (!nRST)
        mul_done |-> ((state == wait_done) && is_mul)
    ) else $error("calc_control got mul_done outside a multiply");

endmodule

// File: source/calc_pkg.sv
package calc_pkg;

    // Operand and result width used by default
    localparam int calc_width = 16;     // Wraps modulo 2^16

    // Operator keys are one-hot
    typedef enum logic [2:0] {
        op_none = 3'b000,               // No operator key pressed
        op_add  = 3'b001,               // Addition
        op_sub  = 3'b010,               // Subtraction
        op_mul  = 3'b100                // Multiplication
    } op_e;

    // Raw keypad code
    typedef logic [3:0] digit_t;        // Zero means no key

    // Operand pair sent to both arithmetic units
    typedef struct packed {
        logic [calc_width-1:0] a;       // First operand
        logic [calc_width-1:0] b;       // Second operand
    } operands_t;                       // 32 bits total

endpackage

// File: source/calc_top.sv
`timescale 1ns/1ps

module calc_top #(
    parameter int Width = calc_pkg::calc_width      // Must match the package width
) (
    input  logic             clk,
    input  logic             nRST,
    input  calc_pkg::digit_t keypad,                // Zero means no key
    input  calc_pkg::op_e    operator,              // One-hot operator key
    input  logic             equal,                 // Equal key
    output logic             complete,              // One-cycle done strobe
    output logic [Width-1:0] result                 // Binary result
);

    logic                enter_a;
    logic                enter_b;
    logic                clear;
    logic [Width-1:0]    value_a;
    logic [Width-1:0]    value_b;
    calc_pkg::operands_t operands;                  // Pair to both units
    logic                sub;
    logic                start_add;
    logic                start_mul;
    logic                add_done;
    logic                mul_done;
    logic [Width-1:0]    add_result;
    logic [Width-1:0]    mul_result;

    calc_control #(.Width(Width)) i_control (
        .clk, .nRST, .operator, .equal, .value_a, .value_b,
        .add_done, .mul_done, .add_result, .mul_result,
        .enter_a, .enter_b, .clear, .start_add, .start_mul, .sub,
        .operands, .complete, .result
    );

    digit_accumulator #(.Width(Width)) i_acc_a (
        .clk, .nRST, .enable(enter_a), .clear, .digit(keypad), .value(value_a)
    );

    digit_accumulator #(.Width(Width)) i_acc_b (
        .clk, .nRST, .enable(enter_b), .clear, .digit(keypad), .value(value_b)
    );

    serial_add_sub #(.Width(Width)) i_add_sub (
        .clk, .nRST, .start(start_add), .sub, .operands,
        .done(add_done), .result(add_result)
    );

    shift_add_multiplier #(.Width(Width)) i_mul (
        .clk, .nRST, .start(start_mul), .operands,
        .done(mul_done), .result(mul_result)
    );

    // operands_t is sized by the package
    a_width_match: assert property (
        @(posedge clk) disable iff (!nRST)
        Width == calc_pkg::calc_width
    ) else $error("calc_top Width %0d differs from calc_width", Width);

endmodule

// File: source/digit_accumulator.sv
`timescale 1ns/1ps

module digit_accumulator #(
    parameter int Width = calc_pkg::calc_width      // Operand width
) (
    input  logic             clk,
    input  logic             nRST,
    input  logic             enable,                // Entry window from control
    input  logic             clear,                 // Empties the register
    input  calc_pkg::digit_t digit,                 // Keypad code
    output logic [Width-1:0] value                  // Binary operand so far
);

    logic [Width-1:0] times_ten;                    // Current value scaled by ten
    logic             key_hit;                      // A digit is present

    assign times_ten = (value << 3) + (value << 1); // 8x plus 2x
    assign key_hit   = (digit != 4'd0);

    // Operand register
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            value <= '0;
        end else if (clear) begin                   // Clear wins over entry
            value <= '0;
        end else if (enable && key_hit) begin
            value <= times_ten + Width'(digit);     // Wraps at 2^Width
        end
    end

    // Only decimal digits may reach the register
    a_digit_range: assert property (
        @(posedge clk) disable iff (!nRST)
        (enable && !clear && key_hit) |-> (digit <= 4'd9)
    ) else $error("digit_accumulator accepted non-decimal digit %0d", digit);

endmodule

// File: source/serial_add_sub.sv
`timescale 1ns/1ps

module serial_add_sub #(
    parameter int Width = calc_pkg::calc_width      // Operand width
) (
    input  logic                clk,
    input  logic                nRST,
    input  logic                start,              // One-cycle launch pulse
    input  logic                sub,                // High for a minus b
    input  calc_pkg::operands_t operands,           // Sampled on start
    output logic                done,               // One-cycle finish pulse
    output logic [Width-1:0]    result              // Stable from done
);

    localparam int Slices = Width / 4;              // Nibbles per run
    localparam int CountW = $clog2(Slices);

    logic              busy;                        // Run in progress
    logic [CountW-1:0] count;                       // Slice index
    logic [Width-1:0]  a_q;                         // Shifting copy of a
    logic [Width-1:0]  b_q;                         // Shifting copy of b or ~b
    logic              carry_q;                     // Carry between slices
    logic [4:0]        slice_sum;                   // Nibble sum with carry out

    assign slice_sum = {1'b0, a_q[3:0]} + {1'b0, b_q[3:0]} + {4'd0, carry_q};

    // Sequencing
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy  <= 1'b0;
            count <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;                           // Pulse by default
            if (start && !busy) begin
                busy  <= 1'b1;
                count <= '0;
            end else if (busy) begin
                count <= count + 1'b1;
                if (count == CountW'(Slices - 1)) begin // Last nibble
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // Datapath, one nibble per cycle from the low end
    always_ff @(posedge clk) begin
        if (start && !busy) begin
            a_q     <= operands.a;
            b_q     <= sub ? ~operands.b : operands.b; // Two's complement via ~b
            carry_q <= sub;                         // Plus one for subtract
        end else if (busy) begin
            a_q     <= a_q >> 4;
            b_q     <= b_q >> 4;
            carry_q <= slice_sum[4];
            result  <= {slice_sum[3:0], result[Width-1:4]}; // Fill from the top
        end
    end

    // Control must wait for done before starting again
    a_no_start_busy: assert property (
        @(posedge clk) disable iff (!nRST)
        busy |-> !start
    ) else $error("serial_add_sub got start while busy");

endmodule

// File: source/shift_add_multiplier.sv
`timescale 1ns/1ps

module shift_add_multiplier #(
    parameter int Width = calc_pkg::calc_width      // Operand width
) (
    input  logic                clk,
    input  logic                nRST,
    input  logic                start,              // One-cycle launch pulse
    input  calc_pkg::operands_t operands,           // Sampled on start
    output logic                done,               // One-cycle finish pulse
    output logic [Width-1:0]    result              // Low Width bits of product
);

    localparam int CountW = $clog2(Width);          // Bit index width

    logic              busy;                        // Run in progress
    logic [CountW-1:0] count;                       // Multiplier bit index
    logic [Width-1:0]  mcand;                       // Multiplicand shifted left
    logic [Width-1:0]  mplier;                      // Multiplier shifted right

    // Sequencing
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy  <= 1'b0;
            count <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start && !busy) begin
                busy  <= 1'b1;
                count <= '0;
            end else if (busy) begin
                count <= count + 1'b1;
                if (count == CountW'(Width - 1)) begin  // Top bit handled
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // Partial product accumulation
    always_ff @(posedge clk) begin
        if (start && !busy) begin
            mcand  <= operands.a;
            mplier <= operands.b;
            result <= '0;                           // Fresh product
        end else if (busy) begin
            if (mplier[0]) begin
                result <= result + mcand;           // Wraps at 2^Width
            end
            mcand  <= mcand << 1;                   // Bits above Width drop off
            mplier <= mplier >> 1;
        end
    end

    // done is seen Width plus one edges after its start
    a_done_after_start: assert property (
        @(posedge clk) disable iff (!nRST)
        done |-> $past(start, Width + 1)
    ) else $error("shift_add_multiplier done without a start");

endmodule

// File: testbench/calc_tb.sv
`timescale 1ns/1ps

module calc_tb;

    localparam int Width         = calc_pkg::calc_width;
    localparam int Modulus       = 1 << Width;  // 2^16 wrap
    localparam int DriveDelay    = 2;           // ns after the rising edge
    localparam int TimeoutCycles = 100;         // Per calculation

    logic             clk;
    logic             nRST;
    calc_pkg::digit_t keypad;
    calc_pkg::op_e    operator;
    logic             equal;
    logic             complete;
    logic [Width-1:0] result;

    logic [Width-1:0] expected;                 // Value due at the next complete
    logic             in_calc;                  // Equal pressed, result not yet out
    int               errors;
    int               calc_count;
    int               pulse_count;              // complete pulses seen
    int               seed;

    tb_clock_gen #(.Period(10), .ResetCycles(2)) i_clock (.clk, .nRST);

    calc_top #(.Width(Width)) i_dut (
        .clk, .nRST, .keypad, .operator, .equal, .complete, .result
    );

    // Result value at every completion
    a_result_value: assert property (
        @(posedge clk) disable iff (!nRST)
        complete |-> (result == expected)
    ) else begin
        errors++;
        $display("FAIL: result is %h, expected %h", result, expected);
    end

    // One-cycle strobe
    a_complete_single: assert property (
        @(posedge clk) disable iff (!nRST)
        complete |=> !complete
    ) else begin
        errors++;
        $display("complete stayed high for more than one cycle");
    end

    // No strobe without a calculation, idle included
    a_complete_requested: assert property (
        @(posedge clk) disable iff (!nRST)
        complete |-> in_calc
    ) else begin
        errors++;
        $display("complete rose with no calculation pending");
    end

    // result only moves into a completion
    a_result_hold: assert property (
        @(posedge clk) disable iff (!nRST)
        $changed(result) |-> complete
    ) else begin
        errors++;
        $display("result changed outside a completion");
    end

    always @(negedge clk) begin
        if (nRST && complete) begin
            pulse_count++;                      // Sampled mid-cycle
        end
    end

    task automatic step();
        @(posedge clk);
        #DriveDelay;                            // Inputs change after the edge
    endtask

    // Random operand of 1 to max_digits nonzero digits
    function automatic int random_operand(input int max_digits);
        int len;
        int number;
        len    = 1 + int'({$random(seed)} % max_digits);
        number = 0;
        repeat (len) begin
            number = number * 10 + 1 + int'({$random(seed)} % 9);
        end
        return number;
    endfunction

    // Types a number most significant digit first
    task automatic enter_number(input int number, inout longint acc);
        int digits[$];
        int rest;
        rest = number;
        while (rest > 0) begin
            digits.push_front(rest % 10);
            rest = rest / 10;
        end
        foreach (digits[i]) begin
            if (digits[i] != 0) begin           // Zero is no key
                acc    = (acc * 10 + digits[i]) % Modulus;
                keypad = 4'(digits[i]);
                step();                         // Held one cycle only
                keypad = 4'd0;
                step();
            end
        end
    endtask

    // Waits for complete, optionally pressing stray keys meanwhile
    task automatic wait_complete(input bit noise);
        int cycles;
        bit seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < TimeoutCycles) begin
            step();
            cycles++;
            if (complete) begin
                seen = 1'b1;
            end else if (noise) begin
                keypad = 4'(1 + {$random(seed)} % 9);
                case (int'({$random(seed)} % 3))
                    0:       operator = calc_pkg::op_add;
                    1:       operator = calc_pkg::op_sub;
                    default: operator = calc_pkg::op_mul;
                endcase
            end
        end
        keypad   = 4'd0;
        operator = calc_pkg::op_none;
        if (!seen) begin
            errors++;
            $display("Timeout: no complete within %0d cycles", TimeoutCycles);
        end else begin
            step();                             // Let the strobe cycle be checked
        end
        in_calc = 1'b0;
    endtask

    // One full calculation a op b
    task automatic run_calc(input int a, input calc_pkg::op_e op, input int b,
                            input bit noise);
        longint acc_a;
        longint acc_b;
        longint value;
        acc_a = 0;
        acc_b = 0;
        enter_number(a, acc_a);
        operator = op;                          // Taken in get_first
        step();
        operator = calc_pkg::op_none;
        enter_number(b, acc_b);
        case (op)
            calc_pkg::op_add: value = acc_a + acc_b;
            calc_pkg::op_sub: value = acc_a - acc_b + Modulus;  // Borrow wraps
            default:          value = acc_a * acc_b;
        endcase
        expected = Width'(value % Modulus);
        in_calc  = 1'b1;
        equal    = 1'b1;
        step();
        equal = 1'b0;
        wait_complete(noise);
        calc_count++;
    endtask

    initial begin
        int cycles;
        int a;
        int b;
        seed        = 26;
        keypad      = 4'd0;
        operator    = calc_pkg::op_none;
        equal       = 1'b0;
        expected    = '0;
        in_calc     = 1'b0;
        errors      = 0;
        calc_count  = 0;
        pulse_count = 0;

        cycles = 0;
        while (nRST !== 1'b1 && cycles < 20) begin
            @(posedge clk);
            cycles++;
        end
        if (nRST !== 1'b1) begin
            errors++;
            $display("Reset was never released");
        end
        #DriveDelay;

        assert (complete == 1'b0) else begin
            errors++;
            $display("FAIL: complete is %h after reset, expected 0", complete);
        end
        assert (result == '0) else begin
            errors++;
            $display("FAIL: result is %h after reset, expected 0", result);
        end
        repeat (8) step();                      // Idle, no strobe allowed

        run_calc(123, calc_pkg::op_add, 45, 1'b0);
        run_calc(65535, calc_pkg::op_add, 1, 1'b0);     // Wraps to zero
        run_calc(511, calc_pkg::op_sub, 48, 1'b0);
        run_calc(12, calc_pkg::op_sub, 345, 1'b0);      // Negative wraps
        run_calc(99, calc_pkg::op_mul, 99, 1'b0);
        run_calc(999, calc_pkg::op_mul, 999, 1'b0);     // Product wraps

        for (int i = 0; i < 9; i++) begin
            a = random_operand(4);
            b = random_operand(4);
            case (i % 3)
                0:       run_calc(a, calc_pkg::op_add, b, 1'b0);
                1:       run_calc(a, calc_pkg::op_sub, b, 1'b0);
                default: run_calc(a, calc_pkg::op_mul, b, 1'b0);
            endcase
        end

        repeat (10) step();                     // Result must hold while idle
        assert (result == expected) else begin
            errors++;
            $display("FAIL: result is %h after idle, expected %h", result, expected);
        end
        run_calc(7, calc_pkg::op_add, 8, 1'b0); // Starts from cleared operands

        run_calc(246, calc_pkg::op_mul, 31, 1'b1);      // Stray keys while busy
        run_calc(4321, calc_pkg::op_sub, 1234, 1'b1);
        run_calc(87, calc_pkg::op_add, 96, 1'b1);
        repeat (4) step();

        assert (pulse_count == calc_count) else begin
            errors++;
            $display("FAIL: pulse_count is %h, expected %h", pulse_count, calc_count);
        end

        $display("Calculations %0d, complete pulses %0d, errors %0d",
                 calc_count, pulse_count, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int Period      = 10,             // Clock period in ns
    parameter int ResetCycles = 2               // Rising edges spent in reset
) (
    output logic clk,
    output logic nRST
);

    initial begin
        clk = 1'b0;
        forever #(Period / 2) clk = ~clk;       // 50% duty
    end

    initial begin
        nRST = 1'b0;                            // Active low from time zero
        repeat (ResetCycles) @(posedge clk);
        #1 nRST = 1'b1;                         // Release just after the edge
    end

endmodule

// File: vlog.f
source/calc_pkg.sv
source/digit_accumulator.sv
source/serial_add_sub.sv
source/shift_add_multiplier.sv
source/calc_control.sv
source/calc_top.sv
testbench/tb_clock_gen.sv
testbench/calc_tb.sv
